//--- hdl/aluPkg.sv
// shared types and constants for the 8-bit execution unit; status bit 5 is fixed 1, bit 4 unused
package aluPkg;

    // one data byte
    typedef logic [7:0] byteT;

    // operation code, one per go strobe
    typedef enum logic [3:0] {
        OpAdc,
        OpSbc,
        OpCmp,
        OpAnd,
        OpOra,
        OpEor,
        OpLsr,
        OpRor,
        OpLoad,
        OpSec,
        OpClc,
        OpSed,
        OpCld,
        OpSei,
        OpCli,
        OpClv
    } opE;

    // operand A source and destination register
    typedef enum logic [1:0] {
        RegA,
        RegX,
        RegY
    } regSelE;

    // bit positions in the NV-BDIZC status byte
    localparam int flagC = 0;
    localparam int flagZ = 1;
    localparam int flagI = 2;
    localparam int flagD = 3;
    localparam int flagB = 4;
    localparam int flagU = 5;
    localparam int flagV = 6;
    localparam int flagN = 7;

    // only the unused bit reads 1 out of reset
    localparam byteT statusResetVal = 8'h20;

    // decimal corrections for the low and high digit
    localparam byteT decAdjLow = 8'h06;
    localparam byteT decAdjHigh = 8'h60;

    // largest valid two-digit BCD value
    localparam byteT bcdMax = 8'h99;

endpackage

//--- hdl/execStage.sv
// operand select, ALU and adder hold register; go must be low in the cycle after a sampled go
`timescale 1ns/1ps

module execStage (
    input  logic            rstAll,
    input  logic            rstN,
    input  logic            go,
    input  aluPkg::opE      op,
    input  aluPkg::regSelE  srcSel,
    input  aluPkg::byteT    dataIn,
    input  aluPkg::byteT    srcData,
    input  logic            cFlag,
    output logic            heldValid,
    output aluPkg::opE      heldOp,
    output aluPkg::byteT    heldSum,
    output logic            heldHalfCarry,
    output logic            heldCarry,
    output logic            heldOverflow,
    output logic            wrEn,
    output aluPkg::regSelE  wrSel
);
    import aluPkg::*;

    byteT opA;
    byteT opB;
    logic carryIn;
    logic doWrite;
    byteT aluOut;
    logic halfCarry;
    logic carry;
    logic overflow;

    // operand selection in front of the ALU
    always_comb begin
        opA = (op == OpLoad) ? 8'h00 : srcData;
        // subtract and compare add the inverted operand
        opB = (op == OpSbc || op == OpCmp) ? ~dataIn : dataIn;
        case (op)
            OpAdc, OpSbc, OpRor: carryIn = cFlag;
            OpCmp:               carryIn = 1'b1;
            default:             carryIn = 1'b0;
        endcase
        // compare and flag operations leave the registers alone
        doWrite = (op inside {OpAdc, OpSbc, OpAnd, OpOra, OpEor, OpLsr, OpRor, OpLoad});
    end

    // ALU, sum built in two nibble steps to get the half carry
    always_comb begin
        aluOut = opA | opB;
        halfCarry = 1'b0;
        carry = 1'b0;
        overflow = 1'b0;
        case (op)
            OpAdc, OpSbc, OpCmp: begin
                {halfCarry, aluOut[3:0]} = 5'(opA[3:0]) + 5'(opB[3:0]) + 5'(carryIn);
                {carry, aluOut[7:4]} = 5'(opA[7:4]) + 5'(opB[7:4]) + 5'(halfCarry);
                overflow = (opA[7] == opB[7]) && (aluOut[7] != opA[7]);
            end
            OpAnd: aluOut = opA & opB;
            OpEor: aluOut = opA ^ opB;
            OpLsr, OpRor: begin
                aluOut = {carryIn, opA[7:1]};
                carry = opA[0];
            end
            default: aluOut = opA | opB;
        endcase
    end

    // hold register, payload only captured on go
    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            heldValid <= 1'b0;
            wrEn <= 1'b0;
        end else begin
            heldValid <= go;
            wrEn <= go && doWrite;
        end
        if (go) begin
            heldOp <= op;
            heldSum <= aluOut;
            heldHalfCarry <= halfCarry;
            heldCarry <= carry;
            heldOverflow <= overflow;
            wrSel <= srcSel;
        end
    end

    // no back-to-back strobes, the flags would still be stale
    goSpacing: assert property (@(posedge rstAll) disable iff (!rstN) go |=> !go)
        else $error("go high in two consecutive cycles");

endmodule

//--- hdl/decimalAdjust.sv
// combinational BCD correction of the held sum; only valid for BCD operands with D set
`timescale 1ns/1ps

module decimalAdjust (
    input  aluPkg::opE    heldOp,
    input  aluPkg::byteT  heldSum,
    input  logic          heldHalfCarry,
    input  logic          heldCarry,
    input  logic          dFlag,
    output aluPkg::byteT  result,
    output logic          carryOut
);
    import aluPkg::*;

    logic decAdd;
    logic decSub;
    logic lowOver;
    logic highOver;

    assign decAdd = dFlag && (heldOp == OpAdc);
    assign decSub = dFlag && (heldOp == OpSbc);

    // low digit past 9 or a carry out of it
    assign lowOver = (heldSum[3:0] > 4'd9) || heldHalfCarry;
    // whole byte past 99 or a binary carry
    assign highOver = heldCarry || (heldSum > bcdMax);

    always_comb begin
        result = heldSum;
        carryOut = heldCarry;
        if (decAdd) begin
            if (lowOver) begin
                result = result + decAdjLow;
            end
            if (highOver) begin
                result = result + decAdjHigh;
            end
            carryOut = highOver;
        end else if (decSub) begin
            // a missing carry means that digit borrowed
            if (!heldHalfCarry) begin
                result = result - decAdjLow;
            end
            if (!heldCarry) begin
                result = result - decAdjHigh;
            end
        end
    end

endmodule

//--- hdl/registerFile.sv
// accumulator and index registers; one read port for operand A, one write port for the result
`timescale 1ns/1ps

module registerFile (
    input  logic            rstAll,
    input  logic            rstN,
    input  logic            wrEn,
    input  aluPkg::regSelE  wrSel,
    input  aluPkg::byteT    result,
    input  aluPkg::regSelE  srcSel,
    output aluPkg::byteT    srcData,
    output aluPkg::byteT    acc,
    output aluPkg::byteT    xReg,
    output aluPkg::byteT    yReg
);
    import aluPkg::*;

    // source read for the ALU
    always_comb begin
        case (srcSel)
            RegX:    srcData = xReg;
            RegY:    srcData = yReg;
            default: srcData = acc;
        endcase
    end

    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            acc <= 8'h00;
            xReg <= 8'h00;
            yReg <= 8'h00;
        end else if (wrEn) begin
            case (wrSel)
                RegX:    xReg <= result;
                RegY:    yReg <= result;
                default: acc <= result;
            endcase
        end
    end

    // the encoding left over in regSelE must never reach the write port
    wrSelDefined: assert property (@(posedge rstAll) disable iff (!rstN)
        wrEn |-> (wrSel inside {RegA, RegX, RegY}))
        else $error("write to undefined register select");

endmodule

//--- hdl/statusReg.sv
// NV-BDIZC flags; B reads 0 and bit 5 reads 1, no BIT instruction support
`timescale 1ns/1ps

module statusReg (
    input  logic          rstAll,
    input  logic          rstN,
    input  logic          heldValid,
    input  aluPkg::opE    heldOp,
    input  aluPkg::byteT  result,
    input  logic          carryOut,
    input  logic          heldOverflow,
    output aluPkg::byteT  status,
    output logic          cFlag,
    output logic          dFlag
);
    import aluPkg::*;

    byteT flags;
    logic resZero;

    assign resZero = (result == 8'h00);

    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            flags <= statusResetVal;
        end else if (heldValid) begin
            case (heldOp)
                OpAdc, OpSbc: begin
                    flags[flagN] <= result[7];
                    flags[flagZ] <= resZero;
                    flags[flagC] <= carryOut;
                    // V from the binary sum even in decimal mode
                    flags[flagV] <= heldOverflow;
                end
                OpCmp, OpLsr, OpRor: begin
                    flags[flagN] <= result[7];
                    flags[flagZ] <= resZero;
                    flags[flagC] <= carryOut;
                end
                OpAnd, OpOra, OpEor, OpLoad: begin
                    flags[flagN] <= result[7];
                    flags[flagZ] <= resZero;
                end
                OpSec:   flags[flagC] <= 1'b1;
                OpClc:   flags[flagC] <= 1'b0;
                OpSed:   flags[flagD] <= 1'b1;
                OpCld:   flags[flagD] <= 1'b0;
                OpSei:   flags[flagI] <= 1'b1;
                OpCli:   flags[flagI] <= 1'b0;
                default: flags[flagV] <= 1'b0;
            endcase
        end
    end

    // bit 5 and B keep their reset value, no update writes them
    assign status = flags;

    assign cFlag = flags[flagC];
    assign dFlag = flags[flagD];

    fixedBits: assert property (@(posedge rstAll) disable iff (!rstN)
        status[flagU] && !status[flagB])
        else $error("status fixed bits corrupted");

endmodule

//--- hdl/execUnit.sv
// execution unit top; results and flags land two cycles after go, no stall, no back-to-back go
`timescale 1ns/1ps

module execUnit (
    input  logic            rstAll,
    input  logic            rstN,
    input  logic            go,
    input  aluPkg::opE      op,
    input  aluPkg::regSelE  srcSel,
    input  aluPkg::byteT    dataIn,
    output aluPkg::byteT    acc,
    output aluPkg::byteT    xReg,
    output aluPkg::byteT    yReg,
    output aluPkg::byteT    status,
    output logic            done
);
    import aluPkg::*;

    byteT   srcData;
    logic   cFlag;
    logic   dFlag;
    logic   heldValid;
    opE     heldOp;
    byteT   heldSum;
    logic   heldHalfCarry;
    logic   heldCarry;
    logic   heldOverflow;
    logic   wrEn;
    regSelE wrSel;
    byteT   result;
    logic   carryOut;

    execStage uExec (
        .rstAll(rstAll), .rstN(rstN), .go(go), .op(op), .srcSel(srcSel),
        .dataIn(dataIn), .srcData(srcData), .cFlag(cFlag),
        .heldValid(heldValid), .heldOp(heldOp), .heldSum(heldSum),
        .heldHalfCarry(heldHalfCarry), .heldCarry(heldCarry),
        .heldOverflow(heldOverflow), .wrEn(wrEn), .wrSel(wrSel)
    );

    decimalAdjust uDec (
        .heldOp(heldOp), .heldSum(heldSum), .heldHalfCarry(heldHalfCarry),
        .heldCarry(heldCarry), .dFlag(dFlag), .result(result), .carryOut(carryOut)
    );

    registerFile uRegs (
        .rstAll(rstAll), .rstN(rstN), .wrEn(wrEn), .wrSel(wrSel), .result(result),
        .srcSel(srcSel), .srcData(srcData), .acc(acc), .xReg(xReg), .yReg(yReg)
    );

    statusReg uStatus (
        .rstAll(rstAll), .rstN(rstN), .heldValid(heldValid), .heldOp(heldOp),
        .result(result), .carryOut(carryOut), .heldOverflow(heldOverflow),
        .status(status), .cFlag(cFlag), .dFlag(dFlag)
    );

    // done follows the cycle in which registers and flags were written
    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            done <= 1'b0;
        end else begin
            done <= heldValid;
        end
    end

endmodule

//--- sim/execUnitTb.sv
// random test of execUnit against a model; D is set only by OpSed, so decimal ops also see non-BCD data
`timescale 1ns/1ps

module execUnitTb;
    import aluPkg::*;

    localparam int numOps = 400;
    // two cycles per operation plus margin for reset and drain
    localparam int timeoutCycles = numOps * 5 / 2;

    logic rstAll;
    logic rstN;
    logic go;
    opE op;
    regSelE srcSel;
    byteT dataIn;
    byteT acc;
    byteT xReg;
    byteT yReg;
    byteT status;
    logic done;

    // model state and bookkeeping
    byteT mAcc;
    byteT mX;
    byteT mY;
    byteT mStatus;
    logic [31:0] expQ[$];
    logic [31:0] expState;
    logic [15:0] lfsrState;
    logic [15:0] bits;
    logic [1:0] goHist;
    opE opPick;
    regSelE srcPick;
    byteT dataPick;
    int opIndex;
    int cycleCount;

    execUnit uut (
        .rstAll(rstAll), .rstN(rstN), .go(go), .op(op), .srcSel(srcSel),
        .dataIn(dataIn), .acc(acc), .xReg(xReg), .yReg(yReg), .status(status),
        .done(done)
    );

    always #20 rstAll = ~rstAll;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compareByte(input string name, input byteT got, input byteT exp);
        assert (got === exp)
            else stopRun($sformatf("Fail: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // one LFSR step per bit taken
    task automatic drawBits(input int count, output logic [15:0] val);
        int k;
        val = 16'h0000;
        for (k = 0; k < count; k++) begin
            val = {val[14:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // reference model, one operation applied at issue time
    task automatic applyModel(input opE o, input regSelE s, input byteT d);
        byteT a;
        byteT b;
        byteT r;
        logic [8:0] wide;
        logic [4:0] lowSum;
        logic cin;
        logic cOut;
        logic ovf;
        logic lowFix;
        logic highFix;
        case (s)
            RegX:    a = mX;
            RegY:    a = mY;
            default: a = mAcc;
        endcase
        if (o == OpLoad) begin
            a = 8'h00;
        end
        b = (o == OpSbc || o == OpCmp) ? ~d : d;
        cin = (o == OpCmp) ? 1'b1 : mStatus[flagC];
        // binary sum with the carries out of bit 3 and bit 7
        lowSum = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0000, cin};
        wide = {1'b0, a} + {1'b0, b} + {8'h00, cin};
        ovf = (a[7] == b[7]) && (wide[7] != a[7]);
        r = wide[7:0];
        cOut = wide[8];
        case (o)
            OpAdc: begin
                if (mStatus[flagD]) begin
                    lowFix = (wide[3:0] > 4'd9) || lowSum[4];
                    highFix = wide[8] || (wide[7:0] > bcdMax);
                    r = wide[7:0] + (lowFix ? decAdjLow : 8'h00)
                        + (highFix ? decAdjHigh : 8'h00);
                    cOut = highFix;
                end
            end
            OpSbc: begin
                // a digit borrowed when its carry is missing
                if (mStatus[flagD]) begin
                    r = wide[7:0] - (lowSum[4] ? 8'h00 : decAdjLow)
                        - (wide[8] ? 8'h00 : decAdjHigh);
                end
            end
            OpAnd:   r = a & d;
            OpOra:   r = a | d;
            OpEor:   r = a ^ d;
            OpLoad:  r = d;
            OpLsr: begin
                r = {1'b0, a[7:1]};
                cOut = a[0];
            end
            OpRor: begin
                r = {mStatus[flagC], a[7:1]};
                cOut = a[0];
            end
            default: r = wide[7:0];
        endcase
        if (o inside {OpAdc, OpSbc, OpCmp, OpAnd, OpOra, OpEor, OpLsr, OpRor, OpLoad}) begin
            mStatus[flagN] = r[7];
            mStatus[flagZ] = (r == 8'h00);
        end
        if (o inside {OpAdc, OpSbc, OpCmp, OpLsr, OpRor}) begin
            mStatus[flagC] = cOut;
        end
        if (o inside {OpAdc, OpSbc}) begin
            mStatus[flagV] = ovf;
        end
        case (o)
            OpSec:   mStatus[flagC] = 1'b1;
            OpClc:   mStatus[flagC] = 1'b0;
            OpSed:   mStatus[flagD] = 1'b1;
            OpCld:   mStatus[flagD] = 1'b0;
            OpSei:   mStatus[flagI] = 1'b1;
            OpCli:   mStatus[flagI] = 1'b0;
            OpClv:   mStatus[flagV] = 1'b0;
            default: ;
        endcase
        if (o inside {OpAdc, OpSbc, OpAnd, OpOra, OpEor, OpLsr, OpRor, OpLoad}) begin
            case (s)
                RegX:    mX = r;
                RegY:    mY = r;
                default: mAcc = r;
            endcase
        end
        expQ.push_back({mAcc, mX, mY, mStatus});
    endtask

    // outputs are stable at the falling edge
    always @(negedge rstAll) begin
        if (rstN) begin
            assert (done == goHist[1])
                else stopRun("done did not pulse exactly two cycles after go");
            if (done) begin
                expState = expQ.pop_front();
                compareByte("acc", acc, expState[31:24]);
                compareByte("xReg", xReg, expState[23:16]);
                compareByte("yReg", yReg, expState[15:8]);
                compareByte("status", status, expState[7:0]);
            end
        end
        goHist = {goHist[0], go};
    end

    always @(posedge rstAll) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            stopRun("Error: timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        rstAll = 1'b0;
        rstN = 1'b0;
        go = 1'b0;
        op = OpAdc;
        srcSel = RegA;
        dataIn = 8'h00;
        mAcc = 8'h00;
        mX = 8'h00;
        mY = 8'h00;
        mStatus = statusResetVal;
        lfsrState = 16'd60;
        goHist = 2'b00;
        cycleCount = 0;
        repeat (2) @(posedge rstAll);
        rstN <= 1'b1;
        @(negedge rstAll);
        compareByte("acc", acc, 8'h00);
        compareByte("xReg", xReg, 8'h00);
        compareByte("yReg", yReg, 8'h00);
        compareByte("status", status, statusResetVal);
        assert (done == 1'b0) else stopRun("done is high after reset");
        for (opIndex = 0; opIndex < numOps; opIndex++) begin
            @(posedge rstAll);
            drawBits(4, bits);
            opPick = opE'(bits[3:0]);
            drawBits(2, bits);
            // the unused select encoding falls back to the accumulator
            srcPick = (bits[1:0] == 2'd3) ? RegA : regSelE'(bits[1:0]);
            drawBits(8, bits);
            dataPick = bits[7:0];
            go <= 1'b1;
            op <= opPick;
            srcSel <= srcPick;
            dataIn <= dataPick;
            applyModel(opPick, srcPick, dataPick);
            @(posedge rstAll);
            go <= 1'b0;
        end
        while (expQ.size() != 0) begin
            @(posedge rstAll);
        end
        repeat (3) @(posedge rstAll);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- tb.f
hdl/aluPkg.sv
hdl/execStage.sv
hdl/decimalAdjust.sv
hdl/registerFile.sv
hdl/statusReg.sv
hdl/execUnit.sv
sim/execUnitTb.sv

//--- Makefile
# Verilator build and run of the execution unit testbench

SOURCES := $(shell cat tb.f)

all: run

obj_dir/VexecUnitTb: tb.f $(SOURCES)
	verilator --binary --timing --assert --top-module execUnitTb -f tb.f -o VexecUnitTb

run: obj_dir/VexecUnitTb
	obj_dir/VexecUnitTb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
